/* rtl/memPkg.sv */
`default_nettype none

package memPkg;

    // datapath and address width
    localparam int wordW = 32;

    // local data RAM depth in words
    localparam int ramWords = 256;
    localparam int ramAddrW = $clog2(ramWords);

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } memSize_t;

    // cp0 control type
    typedef enum logic [1:0] {
        ctNone      = 2'd0,
        ctException = 2'd1,
        ctEret      = 2'd2
    } ctype_t;

    typedef struct packed {
        logic     regwrite;
        logic     memtoreg;
        logic     memwrite;
        memSize_t msize;
        logic     unsignedLoad;
    } execCtl_t;

    // one issue slot coming out of execute
    typedef struct packed {
        logic             valid;
        logic [wordW-1:0] pc;
        logic [4:0]       rdst;
        logic [wordW-1:0] aluOut;
        logic [wordW-1:0] srcb;
        execCtl_t         ctl;
        ctype_t           ctype;
        logic [1:0]       tlbExc;
    } execData_t;

    typedef struct packed {
        logic             valid;
        logic             write;
        logic [wordW-1:0] addr;
        memSize_t         size;
        logic [wordW-1:0] data;
        logic [3:0]       strobe;
    } dbusReq_t;

    // same layout as the execute bundle, with merged ctype and tlb code
    typedef execData_t memData_t;

    typedef struct packed {
        logic             valid;
        logic             regwrite;
        logic [4:0]       rdst;
        logic [wordW-1:0] value;
        logic [wordW-1:0] pc;
    } wbData_t;

endpackage

`default_nettype wire

/* rtl/storeAlign.sv */
`timescale 1ns/1ps
`default_nettype none

module storeAlign (
    input  logic [1:0]               addrLow,
    input  logic [memPkg::wordW-1:0] storeData,
    input  memPkg::memSize_t         size,
    output logic [memPkg::wordW-1:0] data,
    output logic [3:0]               strobe
);

    always_comb begin
        // word store by default
        data   = storeData;
        strobe = 4'b1111;
        case (size)
            memPkg::sizeByte: begin
                data   = {4{storeData[7:0]}};
                strobe = 4'b0001 << addrLow;
            end
            memPkg::sizeHalf: begin
                data   = {2{storeData[15:0]}};
                // low bit of the address is ignored for halves
                strobe = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                data   = storeData;
                strobe = 4'b1111;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/memStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memStage (
    input  memPkg::execData_t [1:0]      dataE,
    input  logic [1:0][1:0]              tlbExc,
    output memPkg::dbusReq_t [1:0]       dreq,
    output memPkg::memData_t [1:0]       dataE2,
    output logic                         excpM
);

    logic [1:0][memPkg::wordW-1:0] storeData;
    logic [1:0][3:0]               storeStrobe;
    logic [1:0]                    hasTlb;
    logic [1:0]                    hasExc;
    logic                          squashYoung;

    for (genvar i = 0; i < 2; i++) begin : genSlot
        storeAlign alignInst (
            .addrLow  (dataE[i].aluOut[1:0]),
            .storeData(dataE[i].srcb),
            .size     (dataE[i].ctl.msize),
            .data     (storeData[i]),
            .strobe   (storeStrobe[i])
        );

        assign hasTlb[i] = |tlbExc[i];
        assign hasExc[i] = (dataE[i].ctype == memPkg::ctException) ||
                           (dataE[i].ctype == memPkg::ctEret);
    end

    // slot 1 is older, so only slot 0 can be squashed
    assign squashYoung = hasExc[1] || (|hasTlb);

    always_comb begin
        dataE2 = dataE;
        for (int i = 0; i < 2; i++) begin
            dataE2[i].tlbExc = tlbExc[i];
            if (hasTlb[i]) begin
                dataE2[i].ctype = memPkg::ctException;
            end
        end
        if (squashYoung) begin
            dataE2[0].ctl.regwrite = 1'b0;
            dataE2[0].ctl.memtoreg = 1'b0;
            dataE2[0].ctl.memwrite = 1'b0;
        end
    end

    // requests come from the cleared control bits
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dreq[i]       = '0;
            dreq[i].valid = dataE2[i].valid && !hasTlb[i] &&
                            (dataE2[i].ctl.memtoreg || dataE2[i].ctl.memwrite);
            dreq[i].write = dataE2[i].ctl.memwrite;
            dreq[i].addr  = dataE2[i].aluOut;
            dreq[i].size  = dataE2[i].ctl.msize;
            if (dataE2[i].ctl.memwrite) begin
                dreq[i].data   = storeData[i];
                dreq[i].strobe = storeStrobe[i];
            end
        end
    end

    // raised for cp0 in the same cycle
    assign excpM = (|hasExc) || (|hasTlb);

endmodule

`default_nettype wire

/* rtl/dataRam.sv */
`timescale 1ns/1ps
`default_nettype none

module dataRam (
    input  logic                          clk,
    input  memPkg::dbusReq_t [1:0]        dreq,
    output logic [1:0][memPkg::wordW-1:0] rdata
);

    logic [memPkg::wordW-1:0]     mem [memPkg::ramWords];
    logic [1:0][memPkg::ramAddrW-1:0] index;

    for (genvar i = 0; i < 2; i++) begin : genIndex
        // word index, byte offset dropped
        assign index[i] = dreq[i].addr[memPkg::ramAddrW+1:2];
    end

    always_ff @(posedge clk) begin
        // slot 1 first so the younger slot 0 lands last on a shared word
        for (int p = 1; p >= 0; p--) begin
            if (dreq[p].valid && dreq[p].write) begin
                for (int b = 0; b < 4; b++) begin
                    if (dreq[p].strobe[b]) begin
                        mem[index[p]][8*b +: 8] <= dreq[p].data[8*b +: 8];
                    end
                end
            end
        end
    end

    // registered read, sees the contents from before this edge
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            rdata[p] <= mem[index[p]];
        end
    end

endmodule

`default_nettype wire

/* rtl/stageReg.sv */
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstN,
    input  payload_t d,
    output payload_t q
);

    // zero payload also means valid low
    always_ff @(posedge clk) begin
        if (!rstN) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* rtl/loadExtract.sv */
`timescale 1ns/1ps
`default_nettype none

module loadExtract (
    input  memPkg::memData_t [1:0]        dataM,
    input  logic [1:0][memPkg::wordW-1:0] rdata,
    output memPkg::wbData_t [1:0]         wb
);

    localparam int byteExt = memPkg::wordW - 8;
    localparam int halfExt = memPkg::wordW - 16;

    for (genvar i = 0; i < 2; i++) begin : genLane
        logic [7:0]               loadByte;
        logic [15:0]              loadHalf;
        logic [memPkg::wordW-1:0] loadValue;

        // byte lane picked by the low address bits
        assign loadByte = rdata[i][8*dataM[i].aluOut[1:0] +: 8];
        assign loadHalf = dataM[i].aluOut[1] ? rdata[i][31:16] : rdata[i][15:0];

        always_comb begin
            case (dataM[i].ctl.msize)
                memPkg::sizeByte: begin
                    if (dataM[i].ctl.unsignedLoad) begin
                        loadValue = {{byteExt{1'b0}}, loadByte};
                    end else begin
                        loadValue = {{byteExt{loadByte[7]}}, loadByte};
                    end
                end
                memPkg::sizeHalf: begin
                    if (dataM[i].ctl.unsignedLoad) begin
                        loadValue = {{halfExt{1'b0}}, loadHalf};
                    end else begin
                        loadValue = {{halfExt{loadHalf[15]}}, loadHalf};
                    end
                end
                default: loadValue = rdata[i];
            endcase
        end

        assign wb[i].valid    = dataM[i].valid;
        assign wb[i].regwrite = dataM[i].ctl.regwrite;
        assign wb[i].rdst     = dataM[i].rdst;
        assign wb[i].pc       = dataM[i].pc;
        // non-load lanes carry the alu result
        assign wb[i].value    = dataM[i].ctl.memtoreg ? loadValue : dataM[i].aluOut;
    end

endmodule

`default_nettype wire

/* rtl/memTop.sv */
`timescale 1ns/1ps
`default_nettype none

module memTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  memPkg::execData_t [1:0] dataE,
    input  logic [1:0][1:0]         tlbExc,
    output logic                    excpM,
    output memPkg::wbData_t [1:0]   wb
);

    memPkg::dbusReq_t [1:0]        dreq;
    memPkg::memData_t [1:0]        dataE2;
    memPkg::memData_t [1:0]        dataM;
    logic [1:0][memPkg::wordW-1:0] rdata;
    memPkg::wbData_t [1:0]         wbNext;

    memStage memStageInst (
        .dataE (dataE),
        .tlbExc(tlbExc),
        .dreq  (dreq),
        .dataE2(dataE2),
        .excpM (excpM)
    );

    dataRam dataRamInst (
        .clk  (clk),
        .dreq (dreq),
        .rdata(rdata)
    );

    // lines the bundle up with the RAM read data
    stageReg #(.payload_t(memPkg::memData_t [1:0])) execReg (
        .clk (clk),
        .rstN(rstN),
        .d   (dataE2),
        .q   (dataM)
    );

    loadExtract loadExtractInst (
        .dataM(dataM),
        .rdata(rdata),
        .wb   (wbNext)
    );

    stageReg #(.payload_t(memPkg::wbData_t [1:0])) wbReg (
        .clk (clk),
        .rstN(rstN),
        .d   (wbNext),
        .q   (wb)
    );

endmodule

`default_nettype wire

/* verification/memAsserts_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module memAsserts (
    input logic                   clk,
    input logic                   rstN,
    input memPkg::dbusReq_t [1:0] dreq,
    input memPkg::wbData_t [1:0]  wb
);

    int failCount = 0;

    for (genvar i = 0; i < 2; i++) begin : genLane
        // a load request carries no byte strobe
        assert property (@(posedge clk) disable iff (!rstN)
            (dreq[i].valid && !dreq[i].write) |-> (dreq[i].strobe == 4'b0000))
            else begin
                $error("slot %0d load request carries a write strobe", i);
                failCount++;
            end

        assert property (@(posedge clk) disable iff (!rstN)
            (dreq[i].valid && dreq[i].write) |-> (dreq[i].strobe != 4'b0000))
            else begin
                $error("slot %0d write request has an empty strobe", i);
                failCount++;
            end
    end

    // wbReg clears on the reset edge
    assert property (@(posedge clk) !rstN |=> (!wb[0].valid && !wb[1].valid))
        else begin
            $error("wb valid high after a reset cycle");
            failCount++;
        end

endmodule

`default_nettype wire

/* verification/memTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memTb;

    localparam int resetCycles = 16;
    // reset plus the cycles each test drives including two flush cycles per test
    localparam int stimCycles = resetCycles + 34 + 42 + 34 + 26 + 26 + 18;

    typedef struct packed {
        memPkg::wbData_t [1:0] wb;
        logic                  excp;
    } expect_t;

    logic                    clk;
    logic                    rstN;
    memPkg::execData_t [1:0] dataE;
    logic [1:0][1:0]         tlbExc;
    logic                    excpM;
    memPkg::wbData_t [1:0]   wb;

    logic [memPkg::wordW-1:0] shadow [memPkg::ramWords];
    expect_t                  expQ [$];
    string                    curTest = "reset";
    logic [31:0]              pcCount = 32'h0040_0000;
    int                       testErrs = 0;
    int                       totalErrs = 0;
    int                       failedTests = 0;
    int                       testCount = 0;

    memTop memTop_inst (
        .clk   (clk),
        .rstN  (rstN),
        .dataE (dataE),
        .tlbExc(tlbExc),
        .excpM (excpM),
        .wb    (wb)
    );

    bind memTop memAsserts assertsInst (
        .clk   (clk),
        .rstN  (rstN),
        .dreq  (dreq),
        .wb    (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic memPkg::execData_t memOp(logic rw, logic m2r, logic mw,
            memPkg::memSize_t sz, logic uns, logic [31:0] addr, logic [31:0] src);
        memPkg::execData_t s;
        s = '0;
        s.valid = 1'b1;
        s.rdst = 5'($urandom);
        s.aluOut = addr;
        s.srcb = src;
        s.ctl = '{rw, m2r, mw, sz, uns};
        return s;
    endfunction

    function automatic memPkg::execData_t storeOp(logic [31:0] a, logic [31:0] d,
            memPkg::memSize_t sz);
        return memOp(1'b0, 1'b0, 1'b1, sz, 1'b0, a, d);
    endfunction

    function automatic memPkg::execData_t loadOp(logic [31:0] a, memPkg::memSize_t sz,
            logic uns);
        return memOp(1'b1, 1'b1, 1'b0, sz, uns, a, 32'd0);
    endfunction

    function automatic memPkg::execData_t aluOp(logic [31:0] v);
        return memOp(1'b1, 1'b0, 1'b0, memPkg::sizeWord, 1'b0, v, 32'd0);
    endfunction

    // distinct word addresses spread over the RAM
    function automatic logic [31:0] spreadAddr(int j);
        return 32'(((j * 7 + 3) % 256) * 4);
    endfunction

    function automatic logic [31:0] extractLoad(logic [31:0] w, logic [1:0] off,
            memPkg::memSize_t sz, logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (sz)
            memPkg::sizeByte: return uns ? {24'd0, b} : {{24{b[7]}}, b};
            memPkg::sizeHalf: return uns ? {16'd0, h} : {{16{h[15]}}, h};
            default: return w;
        endcase
    endfunction

    // expected writeback and exception flag for one bundle and its shadow RAM update
    function automatic expect_t refModel(memPkg::execData_t [1:0] e, logic [1:0][1:0] tlb);
        expect_t    r;
        logic       squash;
        logic [1:0] live;
        squash = (e[1].ctype != memPkg::ctNone) || (tlb != '0);
        r.excp = squash || (e[0].ctype != memPkg::ctNone);
        live = {1'b1, !squash};
        // loads see the RAM from before this bundle's stores
        for (int i = 0; i < 2; i++) begin
            r.wb[i].valid = e[i].valid;
            r.wb[i].regwrite = e[i].ctl.regwrite && live[i];
            r.wb[i].rdst = e[i].rdst;
            r.wb[i].pc = e[i].pc;
            r.wb[i].value = e[i].aluOut;
            if (e[i].ctl.memtoreg && live[i]) begin
                r.wb[i].value = extractLoad(shadow[e[i].aluOut[9:2]], e[i].aluOut[1:0],
                                            e[i].ctl.msize, e[i].ctl.unsignedLoad);
            end
        end
        // older slot first so the younger one lands on top
        for (int i = 1; i >= 0; i--) begin
            if (e[i].valid && e[i].ctl.memwrite && live[i] && tlb[i] == 2'b00) begin
                case (e[i].ctl.msize)
                    memPkg::sizeByte:
                        shadow[e[i].aluOut[9:2]][8*e[i].aluOut[1:0] +: 8] = e[i].srcb[7:0];
                    memPkg::sizeHalf:
                        shadow[e[i].aluOut[9:2]][16*e[i].aluOut[1] +: 16] = e[i].srcb[15:0];
                    default: shadow[e[i].aluOut[9:2]] = e[i].srcb;
                endcase
            end
        end
        return r;
    endfunction

    task automatic drive(memPkg::execData_t older, memPkg::execData_t younger,
            logic [1:0][1:0] tlb);
        memPkg::execData_t [1:0] e;
        @(posedge clk);
        e = {older, younger};
        e[1].pc = pcCount;
        e[0].pc = pcCount + 4;
        pcCount = pcCount + 8;
        dataE <= e;
        tlbExc <= tlb;
        expQ.push_back(refModel(e, tlb));
    endtask

    task automatic checkValue(string what, logic [95:0] expV, logic [95:0] actV);
        if (actV !== expV) begin
            $display("FAILED %s: expected %h, actual %h", what, expV, actV);
            testErrs++;
            totalErrs++;
        end
    endtask

    // two idle bundles push the last results through writeback
    task automatic finishTest();
        drive('0, '0, '0);
        drive('0, '0, '0);
        @(negedge clk);
        #1;
        testCount++;
        if (testErrs == 0) begin
            $display("test %s: ok", curTest);
        end else begin
            $display("test %s: %0d mismatches", curTest, testErrs);
            failedTests++;
        end
        testErrs = 0;
    endtask

    always @(negedge clk) begin : compareBlk
        expect_t x;
        if (expQ.size() > 0) begin
            checkValue($sformatf("%s excpM", curTest), 96'(expQ[$].excp), 96'(excpM));
        end
        // oldest entry is two cycles old and now sits in wb
        if (expQ.size() == 3) begin
            x = expQ.pop_front();
            for (int i = 0; i < 2; i++) begin
                checkValue($sformatf("%s lane %0d", curTest, i), 96'(x.wb[i]), 96'(wb[i]));
            end
        end
    end

    initial begin
        #((stimCycles + 50) * 20);
        $display("timeout: run did not finish within %0d cycles", stimCycles + 50);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        memPkg::execData_t s1;
        memPkg::execData_t s0;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [1:0]        off;
        logic [1:0]        code;
        int                assertFails;
        void'($urandom(26));
        rstN = 1'b0;
        // live bundles during reset so the cleared pipeline registers matter
        dataE = {aluOp($urandom), aluOp($urandom)};
        tlbExc = '0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        curTest = "word store then load";
        for (int j = 0; j < 32; j += 2) begin
            drive(storeOp(spreadAddr(j), $urandom, memPkg::sizeWord),
                  storeOp(spreadAddr(j + 1), $urandom, memPkg::sizeWord), '0);
        end
        for (int j = 0; j < 32; j += 2) begin
            drive(loadOp(spreadAddr(j), memPkg::sizeWord, 1'b0),
                  loadOp(spreadAddr(j + 1), memPkg::sizeWord, 1'b0), '0);
        end
        finishTest();

        curTest = "byte and half lanes";
        for (int it = 0; it < 8; it++) begin
            a = 32'h200 + 32'(it * 8);
            b = a + 4;
            off = 2'(it);
            drive(storeOp(a, $urandom, memPkg::sizeWord),
                  storeOp(b, $urandom, memPkg::sizeWord), '0);
            drive(storeOp(a + off, $urandom, memPkg::sizeByte),
                  storeOp(b + off, $urandom, memPkg::sizeHalf), '0);
            drive(loadOp(a + off, memPkg::sizeByte, 1'b0),
                  loadOp(a + off, memPkg::sizeByte, 1'b1), '0);
            drive(loadOp(b + off, memPkg::sizeHalf, 1'b0),
                  loadOp(b + off, memPkg::sizeHalf, 1'b1), '0);
            drive(loadOp(a, memPkg::sizeWord, 1'b0), loadOp(b, memPkg::sizeWord, 1'b0), '0);
        end
        finishTest();

        curTest = "same word dual store";
        for (int it = 0; it < 8; it++) begin
            a = 32'h300 + 32'(it * 4);
            off = 2'(it);
            drive(storeOp(a, $urandom, memPkg::sizeWord), aluOp($urandom), '0);
            drive(storeOp(a, $urandom, memPkg::sizeWord), storeOp(a + off, $urandom,
                  (it % 2 == 1) ? memPkg::sizeByte : memPkg::sizeHalf), '0);
            // younger load next to an older store still reads the old word
            drive(storeOp(a + off, $urandom, memPkg::sizeByte),
                  loadOp(a, memPkg::sizeWord, 1'b0), '0);
            drive(loadOp(a, memPkg::sizeWord, 1'b0), aluOp($urandom), '0);
        end
        finishTest();

        curTest = "older exception squash";
        for (int it = 0; it < 8; it++) begin
            a = 32'h380 + 32'(it * 4);
            drive(storeOp(a, $urandom, memPkg::sizeWord), aluOp($urandom), '0);
            s1 = aluOp($urandom);
            s1.ctype = (it % 2 == 0) ? memPkg::ctException : memPkg::ctEret;
            s0 = (it < 4) ? storeOp(a, $urandom, memPkg::sizeWord) : aluOp($urandom);
            drive(s1, s0, '0);
            drive(loadOp(a, memPkg::sizeWord, 1'b0), aluOp($urandom), '0);
        end
        finishTest();

        curTest = "tlb miss drop";
        for (int it = 0; it < 8; it++) begin
            a = 32'h3c0 + 32'(it * 8);
            b = a + 4;
            code = (it < 4) ? 2'd1 : 2'd2;
            drive(storeOp(a, $urandom, memPkg::sizeWord),
                  storeOp(b, $urandom, memPkg::sizeWord), '0);
            // miss in the older slot on even passes and in the younger on odd ones
            drive(storeOp(a, $urandom, memPkg::sizeWord),
                  storeOp(b, $urandom, memPkg::sizeWord),
                  (it % 2 == 0) ? {code, 2'b00} : {2'b00, code});
            drive(loadOp(a, memPkg::sizeWord, 1'b0), loadOp(b, memPkg::sizeWord, 1'b0), '0);
        end
        finishTest();

        curTest = "alu passthrough";
        for (int k = 0; k < 16; k++) begin
            s1 = aluOp($urandom);
            s0 = aluOp($urandom);
            s1.ctl.regwrite = 1'($urandom);
            s0.ctl.regwrite = 1'($urandom);
            drive(s1, s0, '0);
        end
        finishTest();

        assertFails = memTop_inst.assertsInst.failCount;
        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 testCount, failedTests, totalErrs, assertFails);
        if (totalErrs == 0 && failedTests == 0 && assertFails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/memPkg.sv
rtl/storeAlign.sv
rtl/memStage.sv
rtl/dataRam.sv
rtl/stageReg.sv
rtl/loadExtract.sv
rtl/memTop.sv
verification/memAsserts_asserts.sv
verification/memTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the memory stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module memTb -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VmemTb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the pass line decides the result
if grep -qF '*** PASSED ***' <<< "$output"; then
    exit 0
fi
exit 1
